/* fpalu_cfg.svh */
// FP ALU datapath widths, exponent biases and Booth multiplier constants
`ifndef FPALU_CFG_SVH
`define FPALU_CFG_SVH

// Adder view, FP29 with right-aligned denormal mantissa
`define FP_MAN_W 22
`define FP_EXP_W 6
`define FP_BIAS 31

// Sum width, one carry bit over the mantissa
`define MAG_W 23
`define LZ_W 5

// Multiply view, FP16 held in the low bits of each field
`define ML_MAN_W 11
`define ML_EXP_W 5
`define ML_BIAS 15

// Radix-4 Booth recoding of the 11-bit multiplier
`define BR4_DIGITS 6
`define PP_W 12             // Mantissa times two fits here

// Rebias the product exponent into the adder format
`define MUL_EXP_OFS (`FP_BIAS - 2 * `ML_BIAS + 2)

`endif

/* fpalu_pkg.sv */
// Operand word types that give the adder and multiply views of one 29-bit word
`include "fpalu_cfg.svh"

package fpalu_pkg;

	// Adder operand
	typedef struct packed {
		logic                 sgn;
		logic [`FP_EXP_W-1:0] exp;    // Biased by 31
		logic [`FP_MAN_W-1:0] man;    // Right-aligned, no hidden one
	} fp29_t;

	// Multiply view of the same bits
	typedef struct packed {
		logic                           sgn;
		logic [`FP_EXP_W-`ML_EXP_W-1:0] exp_pad;   // Ignored by the multiplier
		logic [`ML_EXP_W-1:0]           exp;       // Biased by 15
		logic [`FP_MAN_W-`ML_MAN_W-1:0] man_pad;   // Ignored as well
		logic [`ML_MAN_W-1:0]           man;
	} fp16_t;

	// One operand word, decoded by op_mul
	typedef union packed {
		fp29_t fp29;
		fp16_t fp16;
	} fp_word_u;

endpackage

/* fpalu_if.sv */
// Pipeline bundles between the align, multiply, sum and normalize stages
`timescale 1ns/1ps
`include "fpalu_cfg.svh"

// Aligned adder operands plus the op and valid relays
interface add_if import fpalu_pkg::*; ();
	logic [`FP_MAN_W-1:0] lhs;       // Larger-exponent mantissa
	logic [`FP_MAN_W-1:0] rhs;       // Smaller one, already shifted
	logic                 sub;       // Signs differ
	logic [`FP_EXP_W-1:0] e_large;
	logic                 s_large;   // Sign of lhs
	logic                 skip;      // lhs is zero, pass other operand
	fp29_t                skip_word;
	logic                 mul;       // Op relay
	logic                 valid;

	modport src (output lhs, rhs, sub, e_large, s_large, skip, skip_word, mul, valid);
	modport dst (input lhs, rhs, sub, e_large, s_large, skip, skip_word, mul, valid);
endinterface

// Booth partial sums ready for the shared adder
interface mul_if ();
	logic [`MAG_W-1:0]    ps0;
	logic [`MAG_W-1:0]    ps1;
	logic                 corr;     // Sign bit of digit 0, enters as carry
	logic [`FP_EXP_W-1:0] e_sum;    // ea5 + eb5
	logic                 sgn;

	modport src (output ps0, ps1, corr, e_sum, sgn);
	modport dst (input ps0, ps1, corr, e_sum, sgn);
endinterface

// Unnormalized result into the output stage
interface norm_if import fpalu_pkg::*; ();
	logic [`MAG_W-1:0]    mag;
	logic [`FP_EXP_W-1:0] e0;       // Exponent before lz adjust
	logic                 sgn;
	logic                 skip;
	fp29_t                skip_word;
	logic                 valid;

	modport src (output mag, e0, sgn, skip, skip_word, valid);
	modport dst (input mag, e0, sgn, skip, skip_word, valid);
endinterface

/* add_align.sv */
// Adder front end with exponent compare, operand swap, alignment shift and zero-skip flag
`timescale 1ns/1ps
`include "fpalu_cfg.svh"

module add_align import fpalu_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  fp_word_u a,
	input  fp_word_u b,
	input  logic     op_mul,
	input  logic     in_valid,
	add_if.src       add
);

	// Stage 1 compare
	logic [`FP_EXP_W:0]   exp_diff;   // Extra bit holds the borrow
	logic                 b_larger;
	logic [`FP_EXP_W-1:0] d_abs;

	// Stage 1 registers
	fp29_t                l_q;        // Larger-exponent operand
	fp29_t                s_q;        // The other one
	logic [`FP_EXP_W-1:0] d_q;
	logic                 op_q;
	logic                 vld_q;

	// Stage 2 shifter
	logic [`FP_MAN_W-1:0] s_aligned;

	assign exp_diff = {1'b0, a.fp29.exp} - {1'b0, b.fp29.exp};
	assign b_larger = exp_diff[`FP_EXP_W];   // Borrow means eb > ea, ties stay with A
	assign d_abs    = b_larger ? -exp_diff[`FP_EXP_W-1:0] : exp_diff[`FP_EXP_W-1:0];

	always_ff @(posedge clk) begin
		if (b_larger) begin
			l_q <= b.fp29;
			s_q <= a.fp29;
		end else begin
			l_q <= a.fp29;
			s_q <= b.fp29;
		end
		d_q <= d_abs;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			op_q  <= 1'b0;
			vld_q <= 1'b0;
		end else begin
			op_q  <= op_mul;
			vld_q <= in_valid;
		end
	end

	// Everything shifted out at 22 or more
	assign s_aligned = (d_q >= `FP_MAN_W) ? '0 : s_q.man >> d_q;

	always_ff @(posedge clk) begin
		add.lhs       <= l_q.man;
		add.rhs       <= s_aligned;
		add.sub       <= l_q.sgn ^ s_q.sgn;
		add.e_large   <= l_q.exp;
		add.s_large   <= l_q.sgn;
		add.skip      <= ~op_q & ~|l_q.man;   // Zero lhs would wipe out S
		add.skip_word <= s_q;                 // Unshifted, goes out as is
	end

	// Op and valid relays
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			add.mul   <= 1'b0;
			add.valid <= 1'b0;
		end else begin
			add.mul   <= op_q;
			add.valid <= vld_q;
		end
	end

endmodule

/* booth_mul.sv */
// Radix-4 Booth multiplier front end that reduces six partial products to two sums
`timescale 1ns/1ps
`include "fpalu_cfg.svh"

module booth_mul import fpalu_pkg::*; (
	input  logic     clk,
	input  fp_word_u a,
	input  fp_word_u b,
	mul_if.src       mul
);

	localparam int ENC_W  = 2 * `BR4_DIGITS + 2;   // Multiplier plus guard zeros
	localparam int EXT_W  = `MAG_W - `PP_W - 1;
	localparam int HALF   = `BR4_DIGITS / 2;
	localparam logic [`MAG_W-1:0] UNIT = 1;

	// Sum of -2^(PP_W+2i) over a group of rows, replaces sign extension
	function automatic logic [`MAG_W-1:0] sep_const(input int first, input int last);
		logic [`MAG_W-1:0] k;
		k = '0;
		for (int i = first; i <= last; i++) begin
			k = k - (UNIT << (`PP_W + 2 * i));
		end
		return k;
	endfunction

	localparam logic [`MAG_W-1:0] SEP_K0 = sep_const(0, HALF - 1);
	localparam logic [`MAG_W-1:0] SEP_K1 = sep_const(HALF, `BR4_DIGITS - 1);

	logic [ENC_W-1:0]      mr_ext;
	logic [`PP_W-1:0]      pp_n [`BR4_DIGITS];
	logic [`BR4_DIGITS-1:0] neg_n;
	logic [`ML_EXP_W:0]    esum_n;

	logic [`PP_W-1:0]      pp_q [`BR4_DIGITS];
	logic [`BR4_DIGITS-1:0] neg_q;
	logic [`ML_EXP_W:0]    esum_q;
	logic                  sgn_q;

	logic [`MAG_W-1:0]     ps0_n;
	logic [`MAG_W-1:0]     ps1_n;

	assign mr_ext = {{(ENC_W - `ML_MAN_W - 1){1'b0}}, b.fp16.man, 1'b0};
	assign esum_n = {1'b0, a.fp16.exp} + {1'b0, b.fp16.exp};

	// Recode and build one's complement partial products
	always_comb begin
		logic [2:0]       digit;
		logic [`PP_W-1:0] mag;
		for (int i = 0; i < `BR4_DIGITS; i++) begin
			digit    = mr_ext[2*i +: 3];
			neg_n[i] = digit[2] & ~(digit[1] & digit[0]);
			if (digit[1] ^ digit[0])
				mag = {1'b0, a.fp16.man};          // +-1
			else if (digit[2] ^ digit[1])
				mag = {a.fp16.man, 1'b0};          // +-2
			else
				mag = '0;
			pp_n[i] = neg_n[i] ? ~mag : mag;    // +1 added later
		end
	end

	always_ff @(posedge clk) begin
		pp_q   <= pp_n;
		neg_q  <= neg_n;
		esum_q <= esum_n;
		sgn_q  <= a.fp16.sgn ^ b.fp16.sgn;
	end

	// Low half of rows into ps0, high half into ps1
	always_comb begin
		logic [`MAG_W-1:0] row;
		ps0_n = SEP_K0;
		ps1_n = SEP_K1;
		for (int i = 0; i < `BR4_DIGITS; i++) begin
			row = {{EXT_W{1'b0}}, ~neg_q[i], pp_q[i]} << (2 * i);
			if (i > 0 && neg_q[i])
				row = row + (UNIT << (2 * i));  // Digit 0 uses corr instead
			if (i < HALF)
				ps0_n = ps0_n + row;
			else
				ps1_n = ps1_n + row;
		end
	end

	always_ff @(posedge clk) begin
		mul.ps0   <= ps0_n;
		mul.ps1   <= ps1_n;
		mul.corr  <= neg_q[0];
		mul.e_sum <= esum_q;
		mul.sgn   <= sgn_q;
	end

endmodule

/* sum_select.sv */
// Shared carry-lookahead sum for both ops with sign fix-up and result select
`timescale 1ns/1ps
`include "fpalu_cfg.svh"

module sum_select (
	input  logic clk,
	input  logic rst_n,
	add_if.dst   add,
	mul_if.dst   mul,
	norm_if.src  norm
);

	localparam logic [`FP_EXP_W-1:0] MUL_OFS = `MUL_EXP_OFS;

	logic [`MAG_W-1:0]    cla_a;
	logic [`MAG_W-1:0]    cla_b;
	logic                 cla_cin;
	logic [`MAG_W-1:0]    g;
	logic [`MAG_W-1:0]    p;
	logic [`MAG_W-1:0]    carry;       // Carry into each bit
	logic [`MAG_W-1:0]    cla_s;
	logic                 grp_g;
	logic                 grp_p;
	logic                 grp_c;       // Carry into current 4-bit group
	logic                 diff_neg;
	logic [`MAG_W-1:0]    mag_n;
	logic                 sgn_n;
	logic [`FP_EXP_W-1:0] e0_n;

	// Operand mux, subtract as invert plus carry-in
	always_comb begin
		if (add.mul) begin
			cla_a   = mul.ps0;
			cla_b   = mul.ps1;
			cla_cin = mul.corr;
		end else begin
			cla_a   = {1'b0, add.lhs};
			cla_b   = add.sub ? ~{1'b0, add.rhs} : {1'b0, add.rhs};
			cla_cin = add.sub;
		end
	end

	assign g = cla_a & cla_b;
	assign p = cla_a ^ cla_b;

	// Lookahead inside 4-bit groups, groups chained
	always_comb begin
		grp_c = cla_cin;
		grp_g = 1'b0;
		grp_p = 1'b1;
		for (int k = 0; k < `MAG_W; k++) begin
			if (k % 4 == 0) begin
				grp_g = 1'b0;
				grp_p = 1'b1;
			end
			carry[k] = grp_g | (grp_p & grp_c);
			grp_g    = g[k] | (p[k] & grp_g);
			grp_p    = p[k] & grp_p;
			if (k % 4 == 3)
				grp_c = grp_g | (grp_p & grp_c);
		end
	end

	assign cla_s = p ^ carry;

	// Negative difference, S had the larger magnitude
	assign diff_neg = ~add.mul & add.sub & cla_s[`MAG_W-1];
	assign mag_n    = diff_neg ? -cla_s : cla_s;
	assign sgn_n    = add.mul ? mul.sgn : (add.s_large ^ diff_neg);
	assign e0_n     = add.mul ? (mul.e_sum + MUL_OFS) : (add.e_large + 1'b1);

	always_ff @(posedge clk) begin
		norm.mag       <= mag_n;
		norm.e0        <= e0_n;
		norm.sgn       <= sgn_n;
		norm.skip      <= add.skip;
		norm.skip_word <= add.skip_word;
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			norm.valid <= 1'b0;
		else
			norm.valid <= add.valid;
	end

endmodule

/* normalize_out.sv */
// Output stage with leading-zero count, left shift and exponent adjust
`timescale 1ns/1ps
`include "fpalu_cfg.svh"

module normalize_out import fpalu_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_n,
	norm_if.dst                  norm,
	output logic                 y_sgn,
	output logic [`FP_EXP_W-1:0] y_exp,
	output logic [`FP_MAN_W-1:0] y_man,
	output logic                 out_valid
);

	localparam logic [`LZ_W-1:0] LZ_TOP = `MAG_W - 1;

	logic [`LZ_W-1:0]     lz_n;

	// Stage registers
	logic [`LZ_W-1:0]     lz_q;
	logic [`MAG_W-1:0]    mag_q;
	logic [`FP_EXP_W-1:0] e0_q;
	logic                 sgn_q;
	logic                 skip_q;
	fp29_t                skip_word_q;
	logic                 vld_q;

	logic [`MAG_W-1:0]    shifted;

	// Highest set bit wins, zero mag handled below
	always_comb begin
		lz_n = '0;
		for (int i = 0; i < `MAG_W; i++) begin
			if (norm.mag[i])
				lz_n = LZ_TOP - i[`LZ_W-1:0];
		end
	end

	always_ff @(posedge clk) begin
		lz_q        <= lz_n;
		mag_q       <= norm.mag;
		e0_q        <= norm.e0;
		sgn_q       <= norm.sgn;
		skip_q      <= norm.skip;
		skip_word_q <= norm.skip_word;
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			vld_q <= 1'b0;
		else
			vld_q <= norm.valid;
	end

	assign shifted = mag_q << lz_q;   // MSB now set

	always_comb begin
		if (skip_q) begin
			y_sgn = skip_word_q.sgn;      // Passthrough of S
			y_exp = skip_word_q.exp;
			y_man = skip_word_q.man;
		end else if (mag_q == '0) begin
			y_sgn = 1'b0;                 // Clean zero
			y_exp = '0;
			y_man = '0;
		end else begin
			y_sgn = sgn_q;
			y_exp = e0_q - {1'b0, lz_q};  // Wraps mod 64
			y_man = shifted[`MAG_W-1:1];  // Top 22 bits
		end
	end

	assign out_valid = vld_q;

endmodule

/* fpalu_top.sv */
// FP ALU top level, FP29 add or FP16 multiply with four-cycle latency
`timescale 1ns/1ps
`include "fpalu_cfg.svh"

module fpalu_top import fpalu_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 op_mul,     // High selects multiply
	input  logic                 in_valid,
	input  logic                 a_sgn,
	input  logic [`FP_EXP_W-1:0] a_exp,
	input  logic [`FP_MAN_W-1:0] a_man,
	input  logic                 b_sgn,
	input  logic [`FP_EXP_W-1:0] b_exp,
	input  logic [`FP_MAN_W-1:0] b_man,
	output logic                 y_sgn,
	output logic [`FP_EXP_W-1:0] y_exp,
	output logic [`FP_MAN_W-1:0] y_man,
	output logic                 out_valid
);

	fp_word_u a_word;
	fp_word_u b_word;

	add_if  add_bus ();
	mul_if  mul_bus ();
	norm_if norm_bus ();

	// Ports into operand words, each stage picks its own view
	assign a_word.fp29 = '{sgn: a_sgn, exp: a_exp, man: a_man};
	assign b_word.fp29 = '{sgn: b_sgn, exp: b_exp, man: b_man};

	// Stages 1 and 2
	add_align add_align_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.a        (a_word),
		.b        (b_word),
		.op_mul   (op_mul),
		.in_valid (in_valid),
		.add      (add_bus)
	);

	booth_mul booth_mul_inst (
		.clk (clk),
		.a   (a_word),
		.b   (b_word),
		.mul (mul_bus)
	);

	// Stage 3
	sum_select sum_select_inst (
		.clk   (clk),
		.rst_n (rst_n),
		.add   (add_bus),
		.mul   (mul_bus),
		.norm  (norm_bus)
	);

	// Stage 4
	normalize_out normalize_out_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.norm      (norm_bus),
		.y_sgn     (y_sgn),
		.y_exp     (y_exp),
		.y_man     (y_man),
		.out_valid (out_valid)
	);

endmodule

/* fpalu_checker.sv */
// Result checker for the FP ALU that tracks queued expectations and the fixed output latency
`timescale 1ns/1ps
`include "fpalu_cfg.svh"

module fpalu_checker import fpalu_pkg::*; #(
	parameter int LATENCY = 4                  // Edges from in_valid to out_valid
) (
	input logic                 clk,
	input logic                 rst_n,
	input logic                 in_valid,
	input logic                 out_valid,
	input logic                 y_sgn,
	input logic [`FP_EXP_W-1:0] y_exp,
	input logic [`FP_MAN_W-1:0] y_man
);

	fp29_t              exp_q [$];          // Expected results in issue order
	int                 tag_q [$];          // Test number of each entry
	logic [LATENCY-1:0] hist;               // in_valid seen at past falling edges
	int                 errors;
	int                 checked;

	initial begin
		errors  = 0;
		checked = 0;
		hist    = '0;
	end

	task automatic push_expect(input fp29_t y, input int test);
		exp_q.push_back(y);
		tag_q.push_back(test);
	endtask

	function automatic int pending();
		return exp_q.size();
	endfunction

	// Lost result, keep the rest of the queue in step
	task automatic drop_expect();
		fp29_t e;
		int    t;
		e = exp_q.pop_front();
		t = tag_q.pop_front();
		$display("out_valid did not rise %0d cycles after in_valid (test %0d)", LATENCY, t);
		errors++;
	endtask

	task automatic compare_result();
		fp29_t e;
		int    t;
		e = exp_q.pop_front();
		t = tag_q.pop_front();
		checked++;
		if (y_sgn !== e.sgn) begin
			$display("Mismatch y_sgn exp=%h got=%h (test %0d)", e.sgn, y_sgn, t);
			errors++;
		end
		if (y_exp !== e.exp) begin
			$display("Mismatch y_exp exp=%h got=%h (test %0d)", e.exp, y_exp, t);
			errors++;
		end
		if (y_man !== e.man) begin
			$display("Mismatch y_man exp=%h got=%h (test %0d)", e.man, y_man, t);
			errors++;
		end
	endtask

	// Falling edge, outputs settled half a cycle
	always @(negedge clk) begin
		if (!rst_n) begin
			hist = '0;
		end else begin
			if ($isunknown(out_valid)) begin
				$display("out_valid is unknown after reset");
				errors++;
			end else if (out_valid && !hist[LATENCY-1]) begin
				$display("out_valid rose with no transaction issued %0d cycles before", LATENCY);
				errors++;
			end else if (!out_valid && hist[LATENCY-1]) begin
				if (exp_q.size() > 0)
					drop_expect();
			end else if (out_valid) begin
				if (exp_q.size() == 0) begin
					$display("out_valid rose but no expected result was queued");
					errors++;
				end else begin
					compare_result();
				end
			end
			hist = {hist[LATENCY-2:0], in_valid};   // Age the issue history
		end
	end

endmodule

/* tb_fpalu.sv */
// Testbench for the FP ALU with xorshift add and multiply traffic against a reference model
`timescale 1ns/1ps
`include "fpalu_cfg.svh"

module tb_fpalu import fpalu_pkg::*; ();

	localparam int N_T1        = 8;
	localparam int N_T2        = 40;
	localparam int N_T3        = 40;
	localparam int N_T4        = 20;
	localparam int N_T5        = 40;
	localparam int N_T6        = 60;
	localparam int N_TESTS     = 6;
	localparam int TOTAL_TXN   = N_T1 + N_T2 + N_T3 + N_T4 + N_T5 + N_T6;
	localparam int CYCLE_LIMIT = 2 * TOTAL_TXN + 10 * N_TESTS;

	logic                 clk;
	logic                 rst_n;
	logic                 op_mul;
	logic                 in_valid;
	logic                 a_sgn;
	logic [`FP_EXP_W-1:0] a_exp;
	logic [`FP_MAN_W-1:0] a_man;
	logic                 b_sgn;
	logic [`FP_EXP_W-1:0] b_exp;
	logic [`FP_MAN_W-1:0] b_man;
	logic                 y_sgn;
	logic [`FP_EXP_W-1:0] y_exp;
	logic [`FP_MAN_W-1:0] y_man;
	logic                 out_valid;

	logic [31:0] rng;          // xorshift state
	int          cycles;
	int          fails;        // Tests with at least one error

	fpalu_top fpalu_top_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.op_mul    (op_mul),
		.in_valid  (in_valid),
		.a_sgn     (a_sgn),
		.a_exp     (a_exp),
		.a_man     (a_man),
		.b_sgn     (b_sgn),
		.b_exp     (b_exp),
		.b_man     (b_man),
		.y_sgn     (y_sgn),
		.y_exp     (y_exp),
		.y_man     (y_man),
		.out_valid (out_valid)
	);

	fpalu_checker fpalu_checker_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.out_valid (out_valid),
		.y_sgn     (y_sgn),
		.y_exp     (y_exp),
		.y_man     (y_man)
	);

	always #10 clk = ~clk;     // 20 ns period

	// Run length guard
	always @(posedge clk) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles with %0d results outstanding",
				cycles, fpalu_checker_inst.pending());
			$display("Test failed");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic roll(output logic [31:0] r);
		rng = xorshift32(rng);
		r   = rng;
	endtask

	// Leading-zero shift and exponent adjust, zero forced clean
	function automatic fp29_t normalize_ref(input logic [22:0] m, input logic [5:0] e0,
			input logic s);
		fp29_t       y;
		logic [22:0] sh;
		logic [5:0]  lz;
		y = '0;
		if (m != '0) begin
			sh = m;
			lz = '0;
			while (!sh[22]) begin
				sh = sh << 1;
				lz = lz + 6'd1;
			end
			y.sgn = s;
			y.exp = e0 - lz;                 // Wraps mod 64
			y.man = sh[22:1];
		end
		return y;
	endfunction

	function automatic fp29_t add_ref(input fp29_t a, input fp29_t b);
		fp29_t       l;
		fp29_t       s;
		logic [5:0]  d;
		logic [21:0] al;
		logic [22:0] m;
		logic        sg;
		if (b.exp > a.exp) begin         // A keeps ties
			l = b;
			s = a;
		end else begin
			l = a;
			s = b;
		end
		d  = l.exp - s.exp;
		al = s.man >> d;                 // Bits past the end are lost
		if (l.man == '0)
			return s;
		if (l.sgn == s.sgn) begin
			m  = {1'b0, l.man} + {1'b0, al};
			sg = l.sgn;
		end else if (l.man >= al) begin
			m  = {1'b0, l.man} - {1'b0, al};
			sg = l.sgn;
		end else begin
			m  = {1'b0, al} - {1'b0, l.man};
			sg = s.sgn;                      // Smaller exponent but larger magnitude
		end
		return normalize_ref(m, l.exp + 6'd1, sg);
	endfunction

	function automatic fp29_t mul_ref(input fp_word_u a, input fp_word_u b);
		logic [22:0] m;
		logic [5:0]  e0;
		m  = {12'b0, a.fp16.man} * {12'b0, b.fp16.man};
		e0 = {1'b0, a.fp16.exp} + {1'b0, b.fp16.exp} + `MUL_EXP_OFS;
		return normalize_ref(m, e0, a.fp16.sgn ^ b.fp16.sgn);
	endfunction

	// One transaction, expectation queued at issue
	task automatic send(input logic op, input fp_word_u a, input fp_word_u b, input int test);
		fp29_t y;
		y = op ? mul_ref(a, b) : add_ref(a.fp29, b.fp29);
		@(posedge clk);
		#2;
		op_mul   = op;
		in_valid = 1'b1;
		a_sgn    = a.fp29.sgn;
		a_exp    = a.fp29.exp;
		a_man    = a.fp29.man;
		b_sgn    = b.fp29.sgn;
		b_exp    = b.fp29.exp;
		b_man    = b.fp29.man;
		fpalu_checker_inst.push_expect(y, test);
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			#2;
			in_valid = 1'b0;
		end
	endtask

	task automatic rand_add_word(output fp_word_u w);
		logic [31:0] r0;
		logic [31:0] r1;
		roll(r0);
		roll(r1);
		w.fp29.sgn = r0[31];
		w.fp29.exp = 6'(24 + r0[15:0] % 33);   // 24 to 56
		w.fp29.man = r1[21:0];
	endtask

	task automatic rand_word(output fp_word_u w);
		logic [31:0] r;
		roll(r);
		w = r[28:0];                           // Pads random too
	endtask

	// Drain the pipe, then one status line
	task automatic finish_test(input int num, input string name, input int base_err);
		idle(1);
		while (fpalu_checker_inst.pending() != 0)
			idle(1);
		idle(1);
		if (fpalu_checker_inst.errors == base_err) begin
			$display("test %0d %s: pass", num, name);
		end else begin
			$display("test %0d %s: FAIL with %0d errors", num, name,
				fpalu_checker_inst.errors - base_err);
			fails++;
		end
	endtask

	initial begin
		fp_word_u    a;
		fp_word_u    b;
		logic [31:0] r;
		int          base;
		clk      = 1'b0;
		rst_n    = 1'b0;
		op_mul   = 1'b0;
		in_valid = 1'b0;
		a_sgn    = 1'b0;
		a_exp    = '0;
		a_man    = '0;
		b_sgn    = 1'b0;
		b_exp    = '0;
		b_man    = '0;
		rng      = 32'd63841;
		cycles   = 0;
		fails    = 0;
		repeat (3) @(posedge clk);
		#2;
		rst_n = 1'b1;

		// 1: quiet output, then isolated transactions for latency
		base = fpalu_checker_inst.errors;
		idle(5);
		for (int i = 0; i < N_T1; i++) begin
			rand_add_word(a);
			rand_add_word(b);
			send(1'b0, a, b, 1);
			idle(1);
		end
		finish_test(1, "reset and latency", base);

		// 2: same signs
		base = fpalu_checker_inst.errors;
		for (int i = 0; i < N_T2; i++) begin
			rand_add_word(a);
			rand_add_word(b);
			b.fp29.sgn = a.fp29.sgn;
			send(1'b0, a, b, 2);
		end
		finish_test(2, "add equal signs", base);

		// 3: opposite signs, odd rows give B the larger value
		base = fpalu_checker_inst.errors;
		for (int i = 0; i < N_T3; i++) begin
			rand_add_word(a);
			rand_add_word(b);
			b.fp29.sgn = ~a.fp29.sgn;
			if (i % 2 == 1) begin
				roll(r);
				b.fp29.exp     = a.fp29.exp + 6'(r[1:0]);
				a.fp29.man[21] = 1'b0;
				b.fp29.man[21] = 1'b1;
			end
			send(1'b0, a, b, 3);
		end
		finish_test(3, "add opposite signs", base);

		// 4: zero larger mantissa and exact cancellation
		base = fpalu_checker_inst.errors;
		for (int i = 0; i < N_T4; i++) begin
			rand_add_word(a);
			rand_add_word(b);
			roll(r);
			case (r[1:0])
				2'd0: begin
					a.fp29.man = '0;
					b.fp29.exp = a.fp29.exp - 6'(r[3:2]);
				end
				2'd1: begin
					b.fp29.man = '0;
					b.fp29.exp = a.fp29.exp + 6'(r[3:2]) + 6'd1;
				end
				2'd2: begin
					b            = a;
					b.fp29.sgn   = ~a.fp29.sgn;  // Cancels to zero
				end
				default: begin
					a.fp29.man = '0;
					b.fp29.man = '0;
					b.fp29.exp = a.fp29.exp;
				end
			endcase
			send(1'b0, a, b, 4);
		end
		finish_test(4, "add skip and zero", base);

		// 5: multiply on the FP16 view
		base = fpalu_checker_inst.errors;
		for (int i = 0; i < N_T5; i++) begin
			rand_word(a);
			rand_word(b);
			send(1'b1, a, b, 5);
		end
		finish_test(5, "multiply", base);

		// 6: mixed ops with occasional gaps
		base = fpalu_checker_inst.errors;
		for (int i = 0; i < N_T6; i++) begin
			roll(r);
			if (r[0]) begin
				rand_word(a);
				rand_word(b);
			end else begin
				rand_add_word(a);
				rand_add_word(b);
			end
			send(r[0], a, b, 6);
			if (r[4:2] == 3'd0)
				idle(1);
		end
		finish_test(6, "mixed back to back", base);

		$display("Summary: %0d of %0d tests passed, %0d results checked, %0d errors",
			N_TESTS - fails, N_TESTS, fpalu_checker_inst.checked, fpalu_checker_inst.errors);
		if (fails == 0 && fpalu_checker_inst.errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* build.f */
+incdir+.
fpalu_pkg.sv
fpalu_if.sv
add_align.sv
booth_mul.sv
sum_select.sv
normalize_out.sv
fpalu_top.sv
fpalu_checker.sv
tb_fpalu.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal
TOP       := tb_fpalu
FILELIST  := build.f
OBJ_DIR   := obj_dir
PASS_MSG  := Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
